// ==== common/rom_map_params.svh ====
`ifndef ROM_MAP_PARAMS_SVH
`define ROM_MAP_PARAMS_SVH

// .NEO header block
`define HEADER_BYTES 4096

// Six little-endian 32-bit sizes: P, S, M, V1, V2, C
`define SIZE_FIELD_FIRST 4
`define SIZE_FIELD_LAST 27

// P ROM beyond this goes to the second program bank
`define PROG_BASE_LIMIT 32'h0010_0000

// Program bank address prefixes
`define FIX_PREFIX 5'b11100
`define MROM_PREFIX 5'b11110

// Idle ADPCM byte
`define ADPCM_SILENCE 8'h80

// Download index values
`define LOAD_INDEX_CART 8'd1
`define LOAD_INDEX_CART_NO_PCM 8'd2

`endif

// ==== common/rom_map_pkg.sv ====
package rom_map_pkg;

	// Cartridge regions in .NEO file order
	typedef enum logic [2:0] {
		REGION_P  = 3'd0,
		REGION_S  = 3'd1,
		REGION_M  = 3'd2,
		REGION_V1 = 3'd3,
		REGION_V2 = 3'd4,
		REGION_C  = 3'd5
	} region_e;

	// Sample and sprite memory, byte address
	typedef logic [25:0] mem_addr_t;

	// Program bank, byte address
	typedef logic [23:0] prog_addr_t;

	// Channel sample address, bank included
	typedef logic [23:0] sample_addr_t;

	// One word of the sample memory
	typedef logic [31:0] sample_word_t;

	// Region length as stored in the header
	typedef logic [31:0] region_size_t;

	// ADPCM-A and ADPCM-B
	localparam int CHANNELS = 2;

endpackage

// ==== logic/cart_loader.sv ====
`timescale 1ns/1ps
`include "rom_map_params.svh"

module cart_loader (
	input  logic                                   CLK_48M,
	input  logic                                   arst_n,
	input  logic                                   ioctl_download,
	input  logic [7:0]                             ioctl_index,
	input  logic                                   ioctl_wr,
	input  logic [26:0]                            ioctl_addr,
	input  logic [7:0]                             ioctl_dout,
	input  logic                                   port1_ack,
	input  logic                                   port2_ack,
	output logic                                   port1_req,
	output rom_map_pkg::prog_addr_t                port1_addr,
	output logic                                   port2_req,
	output rom_map_pkg::mem_addr_t                 port2_addr,
	output logic                                   adpcm_en,
	output rom_map_pkg::sample_addr_t [1:0]        pcm_mask,
	output rom_map_pkg::mem_addr_t [1:0]           pcm_base,
	output rom_map_pkg::prog_addr_t                p2_mask
);

	localparam logic [1:0] PH_IDLE  = 2'd0;
	localparam logic [1:0] PH_ACK   = 2'd1;
	localparam logic [1:0] PH_CHECK = 2'd2;

	rom_map_pkg::region_size_t psize, ssize, msize, v1size, v2size, csize;
	rom_map_pkg::region_size_t v1_mask, v2_mask, bank_mask;
	rom_map_pkg::region_size_t region_len;
	rom_map_pkg::region_e      region;
	logic [25:0]               offset;
	logic [1:0]                phase;
	logic                      merged;
	logic                      cart_active;
	logic                      no_pcm;
	logic                      in_header;
	logic                      acked;

	// Size minus one, rounded up to an all-ones mask
	function automatic rom_map_pkg::region_size_t size_mask(
		input rom_map_pkg::region_size_t size
	);
		rom_map_pkg::region_size_t m;
		m = size - 32'd1;
		m = m | (m >> 1);
		m = m | (m >> 2);
		m = m | (m >> 4);
		m = m | (m >> 8);
		m = m | (m >> 16);
		if (size == '0)
			m = '0;
		return m;
	endfunction

	assign no_pcm      = (ioctl_index == `LOAD_INDEX_CART_NO_PCM);
	assign cart_active = ioctl_download && (ioctl_index == `LOAD_INDEX_CART || no_pcm);
	assign in_header   = (ioctl_addr < `HEADER_BYTES);
	assign acked       = (region <= rom_map_pkg::REGION_M) ? (port1_req == port1_ack) :
	                                                         (port2_req == port2_ack);

	assign v1_mask   = size_mask(v1size);
	assign v2_mask   = size_mask(v2size);
	assign bank_mask = size_mask(psize - `PROG_BASE_LIMIT);

	always_comb begin
		case (region)
			rom_map_pkg::REGION_P:  region_len = psize;
			rom_map_pkg::REGION_S:  region_len = ssize;
			rom_map_pkg::REGION_M:  region_len = msize;
			rom_map_pkg::REGION_V1: region_len = v1size;
			rom_map_pkg::REGION_V2: region_len = v2size;
			default:                region_len = csize;
		endcase
	end

	always_ff @(posedge CLK_48M or negedge arst_n) begin
		if (!arst_n) begin
			port1_req <= 1'b0;
			port2_req <= 1'b0;
			region    <= rom_map_pkg::REGION_P;
			offset    <= '0;
			phase     <= PH_IDLE;
			merged    <= 1'b0;
			{csize, v2size, v1size, msize, ssize, psize} <= '0;
		end else begin
			if (ioctl_wr && cart_active) begin
				if (in_header) begin
					region <= rom_map_pkg::REGION_P;
					offset <= '0;
					if (ioctl_addr >= `SIZE_FIELD_FIRST && ioctl_addr <= `SIZE_FIELD_LAST)
						{csize, v2size, v1size, msize, ssize, psize} <=
							{ioctl_dout, csize, v2size, v1size, msize, ssize, psize[31:8]};
					if (ioctl_addr == `HEADER_BYTES - 1) begin
						// No V2 means ADPCM-A and B share one image
						merged <= (v2size == '0);
						phase  <= PH_CHECK;
					end
				end else begin
					if (region <= rom_map_pkg::REGION_M)
						port1_req <= ~port1_req;
					else if (!(no_pcm && (region == rom_map_pkg::REGION_V1 ||
					                      region == rom_map_pkg::REGION_V2)))
						port2_req <= ~port2_req;
					phase <= PH_ACK;
				end
			end

			case (phase)
				PH_ACK: begin
					if (acked) begin
						offset <= offset + 26'd1;
						phase  <= PH_CHECK;
					end
				end
				PH_CHECK: begin
					// Stays here one cycle per empty region
					if (offset == region_len[25:0]) begin
						offset <= '0;
						if (region == rom_map_pkg::REGION_C)
							phase <= PH_IDLE;
						else
							region <= rom_map_pkg::region_e'(region + 3'd1);
					end else begin
						phase <= PH_IDLE;
					end
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		case (region)
			rom_map_pkg::REGION_S:
				port1_addr = {`FIX_PREFIX, offset[18:5], offset[2:0], ~offset[4], offset[3]};
			rom_map_pkg::REGION_M:
				port1_addr = {`MROM_PREFIX, offset[18:0]};
			default:
				port1_addr = offset[23:0];
		endcase
	end

	always_comb begin
		case (region)
			rom_map_pkg::REGION_V1:
				port2_addr = csize[25:0] + offset;
			rom_map_pkg::REGION_V2:
				port2_addr = csize[25:0] + v1size[25:0] + offset;
			default:
				// Sprite bitplane lanes
				port2_addr = {offset[25:7], ioctl_addr[5:2], ~ioctl_addr[6],
				              ioctl_addr[0], ioctl_addr[1]};
		endcase
	end

	always_ff @(posedge CLK_48M or negedge arst_n) begin
		if (!arst_n) begin
			adpcm_en <= 1'b0;
			pcm_mask <= '0;
			pcm_base <= '0;
			p2_mask  <= '0;
		end else if (cart_active) begin
			adpcm_en    <= !no_pcm;
			pcm_mask[0] <= v1_mask[23:0];
			pcm_mask[1] <= merged ? v1_mask[23:0] : v2_mask[23:0];
			pcm_base[0] <= csize[25:0];
			pcm_base[1] <= csize[25:0] + (merged ? 26'd0 : v1size[25:0]);
			if (psize > `PROG_BASE_LIMIT)
				p2_mask <= bank_mask[23:0];
			else
				p2_mask <= '0;
		end
	end

endmodule

// ==== adpcm/pcm_channel.sv ====
`timescale 1ns/1ps
`include "rom_map_params.svh"

module pcm_channel (
	input  logic                      CLK_48M,
	input  logic                      arst_n,
	input  logic                      adpcm_en,
	input  logic                      pcm_rd,
	input  rom_map_pkg::sample_addr_t pcm_addr,
	input  rom_map_pkg::sample_addr_t pcm_mask,
	input  rom_map_pkg::mem_addr_t    pcm_base,
	input  logic                      ch_ack,
	input  rom_map_pkg::sample_word_t ch_q,
	output logic                      ch_req,
	output rom_map_pkg::mem_addr_t    ch_addr,
	output logic [7:0]                pcm_data,
	output logic                      pcm_ready
);

	logic                      rd_d;
	logic                      rd_rise;
	logic                      word_valid;
	rom_map_pkg::sample_addr_t addr_latch;
	rom_map_pkg::sample_addr_t addr_masked;
	rom_map_pkg::mem_addr_t    addr_next;

	assign rd_rise     = pcm_rd && !rd_d && adpcm_en;
	assign addr_masked = pcm_addr & pcm_mask;
	assign addr_next   = pcm_base + {2'b00, addr_masked};
	assign ch_addr     = pcm_base + {2'b00, addr_latch};
	assign pcm_ready   = (ch_req == ch_ack);

	always_ff @(posedge CLK_48M or negedge arst_n) begin
		if (!arst_n) begin
			rd_d       <= 1'b0;
			word_valid <= 1'b0;
			addr_latch <= '0;
			ch_req     <= 1'b0;
		end else begin
			rd_d <= pcm_rd;
			if (!adpcm_en) begin
				word_valid <= 1'b0;
			end else if (rd_rise) begin
				// Fetch only when the 4-byte word moves
				if (!word_valid || addr_next[25:2] != ch_addr[25:2])
					ch_req <= ~ch_req;
				word_valid <= 1'b1;
				addr_latch <= addr_masked;
			end
		end
	end

	always_comb begin
		if (!adpcm_en) begin
			pcm_data = `ADPCM_SILENCE;
		end else begin
			case (ch_addr[1:0])
				2'd0:    pcm_data = ch_q[7:0];
				2'd1:    pcm_data = ch_q[15:8];
				2'd2:    pcm_data = ch_q[23:16];
				default: pcm_data = ch_q[31:24];
			endcase
		end
	end

endmodule

// ==== adpcm/sample_arbiter.sv ====
`timescale 1ns/1ps
`include "rom_map_params.svh"

module sample_arbiter (
	input  logic                                                  CLK_48M,
	input  logic                                                  arst_n,
	input  logic [rom_map_pkg::CHANNELS-1:0]                      ch_req,
	input  rom_map_pkg::mem_addr_t [rom_map_pkg::CHANNELS-1:0]    ch_addr,
	input  logic                                                  mem_ack,
	input  rom_map_pkg::sample_word_t                             mem_q,
	output logic [rom_map_pkg::CHANNELS-1:0]                      ch_ack,
	output rom_map_pkg::sample_word_t [rom_map_pkg::CHANNELS-1:0] ch_q,
	output logic                                                  mem_req,
	output rom_map_pkg::mem_addr_t                                mem_addr
);

	localparam int OWNER_W = (rom_map_pkg::CHANNELS > 1) ? $clog2(rom_map_pkg::CHANNELS) : 1;

	logic [rom_map_pkg::CHANNELS-1:0] pending;
	logic                             grant_any;
	logic [OWNER_W-1:0]               grant_idx;
	logic [OWNER_W-1:0]               owner;
	logic                             busy;
	logic                             mem_done;

	assign pending  = ch_req ^ ch_ack;
	assign mem_done = busy && (mem_req == mem_ack);

	// Lowest channel wins
	always_comb begin
		grant_any = 1'b0;
		grant_idx = '0;
		for (int i = rom_map_pkg::CHANNELS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				grant_any = 1'b1;
				grant_idx = OWNER_W'(i);
			end
		end
	end

	always_ff @(posedge CLK_48M or negedge arst_n) begin
		if (!arst_n) begin
			busy    <= 1'b0;
			owner   <= '0;
			mem_req <= 1'b0;
			ch_ack  <= '0;
		end else if (mem_done) begin
			ch_ack[owner] <= ~ch_ack[owner];
			busy          <= 1'b0;
		end else if (!busy && grant_any) begin
			mem_req <= ~mem_req;
			owner   <= grant_idx;
			busy    <= 1'b1;
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (!busy && grant_any)
			mem_addr <= ch_addr[grant_idx];
		// Word holds until this channel's next fetch
		if (mem_done)
			ch_q[owner] <= mem_q;
	end

endmodule

// ==== logic/neogeo_rom_ctrl.sv ====
`timescale 1ns/1ps

module neogeo_rom_ctrl (
	input  logic                                                  CLK_48M,
	input  logic                                                  arst_n,
	input  logic                                                  ioctl_download,
	input  logic [7:0]                                            ioctl_index,
	input  logic                                                  ioctl_wr,
	input  logic [26:0]                                           ioctl_addr,
	input  logic [7:0]                                            ioctl_dout,
	output logic                                                  port1_req,
	output rom_map_pkg::prog_addr_t                               port1_addr,
	input  logic                                                  port1_ack,
	output logic                                                  port2_req,
	output rom_map_pkg::mem_addr_t                                port2_addr,
	input  logic                                                  port2_ack,
	output rom_map_pkg::prog_addr_t                               p2_mask,
	input  logic [rom_map_pkg::CHANNELS-1:0]                      pcm_rd,
	input  logic [19:0]                                           pcma_addr,
	input  logic [3:0]                                            pcma_bank,
	input  rom_map_pkg::sample_addr_t                             pcmb_addr,
	output logic [rom_map_pkg::CHANNELS-1:0][7:0]                 pcm_data,
	output logic [rom_map_pkg::CHANNELS-1:0]                      pcm_ready,
	output logic                                                  mem_req,
	output rom_map_pkg::mem_addr_t                                mem_addr,
	input  logic                                                  mem_ack,
	input  rom_map_pkg::sample_word_t                             mem_q
);

	logic                                                  adpcm_en;
	rom_map_pkg::sample_addr_t [rom_map_pkg::CHANNELS-1:0] pcm_mask;
	rom_map_pkg::mem_addr_t [rom_map_pkg::CHANNELS-1:0]    pcm_base;
	rom_map_pkg::sample_addr_t [rom_map_pkg::CHANNELS-1:0] pcm_addr;
	logic [rom_map_pkg::CHANNELS-1:0]                      ch_req;
	logic [rom_map_pkg::CHANNELS-1:0]                      ch_ack;
	rom_map_pkg::mem_addr_t [rom_map_pkg::CHANNELS-1:0]    ch_addr;
	rom_map_pkg::sample_word_t [rom_map_pkg::CHANNELS-1:0] ch_q;

	// ADPCM-A carries its bank above the 20-bit address
	assign pcm_addr[0] = {pcma_bank, pcma_addr};
	assign pcm_addr[1] = pcmb_addr;

	cart_loader u_cart_loader (
		.CLK_48M        (CLK_48M),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.port1_ack      (port1_ack),
		.port2_ack      (port2_ack),
		.port1_req      (port1_req),
		.port1_addr     (port1_addr),
		.port2_req      (port2_req),
		.port2_addr     (port2_addr),
		.adpcm_en       (adpcm_en),
		.pcm_mask       (pcm_mask),
		.pcm_base       (pcm_base),
		.p2_mask        (p2_mask)
	);

	for (genvar i = 0; i < rom_map_pkg::CHANNELS; i++) begin : g_ch
		pcm_channel u_pcm_channel (
			.CLK_48M   (CLK_48M),
			.arst_n    (arst_n),
			.adpcm_en  (adpcm_en),
			.pcm_rd    (pcm_rd[i]),
			.pcm_addr  (pcm_addr[i]),
			.pcm_mask  (pcm_mask[i]),
			.pcm_base  (pcm_base[i]),
			.ch_ack    (ch_ack[i]),
			.ch_q      (ch_q[i]),
			.ch_req    (ch_req[i]),
			.ch_addr   (ch_addr[i]),
			.pcm_data  (pcm_data[i]),
			.pcm_ready (pcm_ready[i])
		);
	end

	sample_arbiter u_sample_arbiter (
		.CLK_48M  (CLK_48M),
		.arst_n   (arst_n),
		.ch_req   (ch_req),
		.ch_addr  (ch_addr),
		.mem_ack  (mem_ack),
		.mem_q    (mem_q),
		.ch_ack   (ch_ack),
		.ch_q     (ch_q),
		.mem_req  (mem_req),
		.mem_addr (mem_addr)
	);

endmodule

// ==== tests/tb_neogeo_rom_ctrl.sv ====
`timescale 1ns/1ps
`include "rom_map_params.svh"

module tb_neogeo_rom_ctrl;

	logic                                                  CLK_48M;
	logic                                                  arst_n;
	logic                                                  ioctl_download;
	logic [7:0]                                            ioctl_index;
	logic                                                  ioctl_wr;
	logic [26:0]                                           ioctl_addr;
	logic [7:0]                                            ioctl_dout;
	logic                                                  port1_req;
	rom_map_pkg::prog_addr_t                               port1_addr;
	logic                                                  port1_ack;
	logic                                                  port2_req;
	rom_map_pkg::mem_addr_t                                port2_addr;
	logic                                                  port2_ack;
	rom_map_pkg::prog_addr_t                               p2_mask;
	logic [rom_map_pkg::CHANNELS-1:0]                      pcm_rd;
	logic [19:0]                                           pcma_addr;
	logic [3:0]                                            pcma_bank;
	rom_map_pkg::sample_addr_t                             pcmb_addr;
	logic [rom_map_pkg::CHANNELS-1:0][7:0]                 pcm_data;
	logic [rom_map_pkg::CHANNELS-1:0]                      pcm_ready;
	logic                                                  mem_req;
	rom_map_pkg::mem_addr_t                                mem_addr;
	logic                                                  mem_ack;
	rom_map_pkg::sample_word_t                             mem_q;

	string                     test_name;
	rom_map_pkg::region_size_t sizes [6];
	logic [7:0]                prog_mem [int];
	logic [7:0]                sample_mem [int];
	logic [7:0]                exp_sample [int];
	rom_map_pkg::prog_addr_t   exp_p1 [$];
	rom_map_pkg::prog_addr_t   got_p1 [$];
	rom_map_pkg::mem_addr_t    exp_p2 [$];
	rom_map_pkg::mem_addr_t    got_p2 [$];
	int                        mem_reads;
	int                        exp_reads;
	int                        last_word [rom_map_pkg::CHANNELS];
	bit                        pcm_on;

	neogeo_rom_ctrl u_neogeo_rom_ctrl (.*);

	initial begin
		CLK_48M = 1'b0;
		forever #5 CLK_48M = ~CLK_48M;
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_prog_addr(input rom_map_pkg::prog_addr_t exp,
	                               input rom_map_pkg::prog_addr_t act);
		if (act !== exp)
			stop_with_failure($sformatf("[FAIL] %s port1_addr expected %h got %h",
			                            test_name, exp, act));
	endtask

	task automatic check_bank_mask(input rom_map_pkg::prog_addr_t exp,
	                               input rom_map_pkg::prog_addr_t act);
		if (act !== exp)
			stop_with_failure($sformatf("[FAIL] %s p2_mask expected %h got %h",
			                            test_name, exp, act));
	endtask

	task automatic check_mem_addr(input rom_map_pkg::mem_addr_t exp,
	                              input rom_map_pkg::mem_addr_t act);
		if (act !== exp)
			stop_with_failure($sformatf("[FAIL] %s port2_addr expected %h got %h",
			                            test_name, exp, act));
	endtask

	task automatic check_pcm_byte(input int ch, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			stop_with_failure($sformatf("[FAIL] %s pcm_data[%0d] expected %h got %h",
			                            test_name, ch, exp, act));
	endtask

	task automatic check_req_count(input int exp, input int act);
		if (act != exp)
			stop_with_failure($sformatf("[FAIL] %s sample requests expected %0d got %0d",
			                            test_name, exp, act));
	endtask

	// Unwritten sample memory
	function automatic logic [7:0] fill_byte(input int a);
		logic [25:0] x;
		x = a[25:0];
		return x[7:0] ^ x[15:8] ^ x[23:16] ^ {6'b0, x[25:24]} ^ 8'h5a;
	endfunction

	function automatic logic [7:0] stored_byte(input int a);
		if (sample_mem.exists(a))
			return sample_mem[a];
		return fill_byte(a);
	endfunction

	function automatic int pow2_mask(input int size);
		int p;
		p = 1;
		while (p < size)
			p = p << 1;
		return p - 1;
	endfunction

	// Second program bank only past the first megabyte of P
	function automatic rom_map_pkg::prog_addr_t exp_bank_mask();
		if (sizes[0] <= `PROG_BASE_LIMIT)
			return '0;
		return 24'(pow2_mask(sizes[0] - `PROG_BASE_LIMIT));
	endfunction

	// V2 size zero means one shared ADPCM image
	function automatic int chan_mask(input int ch);
		if (ch == 1 && sizes[4] != 0)
			return pow2_mask(sizes[4]);
		return pow2_mask(sizes[3]);
	endfunction

	function automatic int chan_base(input int ch);
		if (ch == 1 && sizes[4] != 0)
			return sizes[5] + sizes[3];
		return sizes[5];
	endfunction

	function automatic rom_map_pkg::prog_addr_t exp_port1_addr(input rom_map_pkg::region_e r,
	                                                           input int off);
		logic [25:0] o;
		o = off[25:0];
		case (r)
			rom_map_pkg::REGION_S: return {`FIX_PREFIX, o[18:5], o[2:0], ~o[4], o[3]};
			rom_map_pkg::REGION_M: return {`MROM_PREFIX, o[18:0]};
			default:               return o[23:0];
		endcase
	endfunction

	function automatic rom_map_pkg::mem_addr_t exp_port2_addr(input rom_map_pkg::region_e r,
	                                                          input int off,
	                                                          input logic [26:0] fa);
		logic [25:0] o;
		o = off[25:0];
		case (r)
			rom_map_pkg::REGION_V1: return sizes[5][25:0] + o;
			rom_map_pkg::REGION_V2: return sizes[5][25:0] + sizes[3][25:0] + o;
			default:                return {o[25:7], fa[5:2], ~fa[6], fa[0], fa[1]};
		endcase
	endfunction

	function automatic logic [7:0] exp_pcm_byte(input int ch,
	                                            input rom_map_pkg::sample_addr_t a);
		int loc;
		if (!pcm_on)
			return `ADPCM_SILENCE;
		loc = chan_base(ch) + (a & chan_mask(ch));
		if (exp_sample.exists(loc))
			return exp_sample[loc];
		return fill_byte(loc);
	endfunction

	// A new request only when the word moves
	function automatic void note_fetch(input int ch, input rom_map_pkg::sample_addr_t a);
		int w;
		w = (chan_base(ch) + (a & chan_mask(ch))) >> 2;
		if (pcm_on && w != last_word[ch])
			exp_reads++;
		if (pcm_on)
			last_word[ch] = w;
	endfunction

	// Program memory
	initial begin
		int delay;
		forever begin
			@(posedge CLK_48M);
			#1;
			if (port1_req != port1_ack) begin
				got_p1.push_back(port1_addr);
				prog_mem[port1_addr] = ioctl_dout;
				delay = 1 + ($urandom % 4);
				repeat (delay) @(posedge CLK_48M);
				#1;
				port1_ack = port1_req;
			end
		end
	end

	// Sample memory, write side
	initial begin
		int delay;
		forever begin
			@(posedge CLK_48M);
			#1;
			if (port2_req != port2_ack) begin
				got_p2.push_back(port2_addr);
				sample_mem[port2_addr] = ioctl_dout;
				delay = 1 + ($urandom % 4);
				repeat (delay) @(posedge CLK_48M);
				#1;
				port2_ack = port2_req;
			end
		end
	end

	// Sample memory, read side
	initial begin
		int delay;
		int a;
		forever begin
			@(posedge CLK_48M);
			#1;
			if (mem_req != mem_ack) begin
				mem_reads++;
				a = {mem_addr[25:2], 2'b00};
				delay = 1 + ($urandom % 4);
				repeat (delay) @(posedge CLK_48M);
				#1;
				mem_q = {stored_byte(a + 3), stored_byte(a + 2),
				         stored_byte(a + 1), stored_byte(a)};
				mem_ack = mem_req;
			end
		end
	end

	always @(negedge CLK_48M) begin
		while (got_p1.size() > 0) begin
			if (exp_p1.size() == 0)
				stop_with_failure("program port written with no download byte pending");
			else
				check_prog_addr(exp_p1.pop_front(), got_p1.pop_front());
		end
		while (got_p2.size() > 0) begin
			if (exp_p2.size() == 0)
				stop_with_failure("sample port written with no download byte pending");
			else
				check_mem_addr(exp_p2.pop_front(), got_p2.pop_front());
		end
	end

	task automatic pulse_wr(input int fa, input logic [7:0] d);
		ioctl_addr = fa[26:0];
		ioctl_dout = d;
		ioctl_wr = 1'b1;
		@(posedge CLK_48M);
		#1;
		ioctl_wr = 1'b0;
		@(posedge CLK_48M);
		#1;
	endtask

	// Host pacing, four cycles after the acknowledge
	task automatic wait_port_acks();
		int n;
		n = 0;
		do begin
			@(negedge CLK_48M);
			n++;
			if (n > 50)
				stop_with_failure("timeout waiting for a download write acknowledge");
		end while (port1_req != port1_ack || port2_req != port2_ack);
		repeat (4) @(posedge CLK_48M);
		#1;
	endtask

	task automatic pick_sizes();
		int i;
		for (i = 0; i < 6; i++)
			sizes[i] = 128 * (1 + ($urandom % 3));
	endtask

	task automatic send_header(input logic [7:0] index);
		int fa;
		int k;
		logic [7:0] d;
		ioctl_index = index;
		ioctl_download = 1'b1;
		for (fa = 0; fa < `HEADER_BYTES; fa++) begin
			d = 8'h00;
			if (fa >= `SIZE_FIELD_FIRST && fa <= `SIZE_FIELD_LAST) begin
				k = fa - `SIZE_FIELD_FIRST;
				d = sizes[k / 4][8 * (k % 4) +: 8];
			end
			pulse_wr(fa, d);
		end
		repeat (4) @(posedge CLK_48M);
		#1;
	endtask

	task automatic load_cart(input logic [7:0] index);
		int fa;
		int i;
		int off;
		rom_map_pkg::region_e r;
		rom_map_pkg::mem_addr_t a2;
		logic [7:0] d;
		send_header(index);
		fa = `HEADER_BYTES;
		for (i = 0; i < 6; i++) begin
			r = rom_map_pkg::region_e'(i);
			for (off = 0; off < int'(sizes[i]); off++) begin
				d = 8'($urandom);
				if (r <= rom_map_pkg::REGION_M) begin
					exp_p1.push_back(exp_port1_addr(r, off));
				end else if (index == `LOAD_INDEX_CART || r == rom_map_pkg::REGION_C) begin
					a2 = exp_port2_addr(r, off, fa[26:0]);
					exp_p2.push_back(a2);
					exp_sample[a2] = d;
				end
				pulse_wr(fa, d);
				wait_port_acks();
				fa++;
			end
		end
		ioctl_download = 1'b0;
		pcm_on = (index == `LOAD_INDEX_CART);
		last_word = '{-1, -1};
		if (exp_p1.size() != 0 || exp_p2.size() != 0)
			stop_with_failure("a download byte never reached its memory port");
		check_bank_mask(exp_bank_mask(), p2_mask);
	endtask

	task automatic read_pair(input bit rd0, input rom_map_pkg::sample_addr_t a0,
	                         input bit rd1, input rom_map_pkg::sample_addr_t a1);
		logic [1:0] want;
		int n;
		want = {rd1, rd0};
		if (rd0)
			note_fetch(0, a0);
		if (rd1)
			note_fetch(1, a1);
		pcma_bank = a0[23:20];
		pcma_addr = a0[19:0];
		pcmb_addr = a1;
		pcm_rd = want;
		@(posedge CLK_48M);
		n = 0;
		do begin
			@(negedge CLK_48M);
			n++;
			if (n > 40)
				stop_with_failure("timeout waiting for pcm_ready");
		end while ((pcm_ready & want) != want);
		if (rd0)
			check_pcm_byte(0, exp_pcm_byte(0, a0), pcm_data[0]);
		if (rd1)
			check_pcm_byte(1, exp_pcm_byte(1, a1), pcm_data[1]);
		@(posedge CLK_48M);
		#1;
		pcm_rd = '0;
		@(posedge CLK_48M);
		#1;
	endtask

	initial begin
		int i;
		rom_map_pkg::sample_addr_t a0;
		void'($urandom(32'h98fb));
		arst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		port1_ack = 1'b0;
		port2_ack = 1'b0;
		pcm_rd = '0;
		pcma_addr = '0;
		pcma_bank = '0;
		pcmb_addr = '0;
		mem_ack = 1'b0;
		mem_q = '0;
		mem_reads = 0;
		exp_reads = 0;
		pcm_on = 1'b0;
		last_word = '{-1, -1};
		repeat (2) @(posedge CLK_48M);
		#1;
		arst_n = 1'b1;
		@(posedge CLK_48M);
		#1;

		test_name = "region_walk";
		pick_sizes();
		load_cart(`LOAD_INDEX_CART);

		// Both channels at once, then the rest of channel 0's word
		test_name = "word_reuse";
		a0 = 24'($urandom) & 24'hff_fffc;
		read_pair(1'b1, a0, 1'b1, 24'($urandom));
		for (i = 1; i < 4; i++)
			read_pair(1'b1, a0 | i, 1'b0, '0);
		check_req_count(exp_reads, mem_reads);

		test_name = "sample_fetch";
		for (i = 0; i < 12; i++)
			read_pair(i % 3 != 1, 24'($urandom), i % 3 != 0, 24'($urandom));
		check_req_count(exp_reads, mem_reads);

		test_name = "empty_region_no_pcm";
		pick_sizes();
		sizes[1] = 0;
		load_cart(`LOAD_INDEX_CART_NO_PCM);

		test_name = "adpcm_off";
		for (i = 0; i < 4; i++)
			read_pair(1'b1, 24'($urandom), 1'b1, 24'($urandom));
		check_req_count(exp_reads, mem_reads);

		test_name = "merged_image";
		pick_sizes();
		sizes[4] = 0;
		load_cart(`LOAD_INDEX_CART);
		for (i = 0; i < 10; i++)
			read_pair(i % 2 == 0, 24'($urandom), 1'b1, 24'($urandom));
		check_req_count(exp_reads, mem_reads);

		// Header only, with a P size that needs the second bank
		test_name = "bank_mask";
		pick_sizes();
		sizes[0] = `PROG_BASE_LIMIT + 32'h1000 * (1 + ($urandom % 200));
		send_header(`LOAD_INDEX_CART);
		ioctl_download = 1'b0;
		check_bank_mask(exp_bank_mask(), p2_mask);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+common
common/rom_map_pkg.sv
logic/cart_loader.sv
adpcm/pcm_channel.sv
adpcm/sample_arbiter.sv
logic/neogeo_rom_ctrl.sv
tests/tb_neogeo_rom_ctrl.sv

// ==== Bender.yml ====
package:
  name: neogeo_rom_ctrl

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rom_map_pkg.sv
      - logic/cart_loader.sv
      - adpcm/pcm_channel.sv
      - adpcm/sample_arbiter.sv
      - logic/neogeo_rom_ctrl.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_neogeo_rom_ctrl.sv
